//--- verilog/rtos_defines.svh
// Sizing and identification macros for the kernel, included by every file that needs them
`ifndef RTOS_DEFINES_SVH
`define RTOS_DEFINES_SVH

// --------------------------------------------------
// Kernel object counts
// --------------------------------------------------
`define RTOS_TASKS          8
`define RTOS_SEMAPHORES     4

// --------------------------------------------------
// Field widths
// --------------------------------------------------
// Lower value is higher priority
`define RTOS_TSKPRI_WIDTH   4
// Counter saturates at all ones
`define RTOS_SEMCNT_WIDTH   4
`define RTOS_FLGPTN_WIDTH   32

// Opcode in address bits 7..0, object id in 15..8
`define RTOS_WB_ADR_WIDTH   16

// Identification words
`define RTOS_CORE_ID        32'h834f_5452
`define RTOS_CORE_VERSION   32'h0000_0100

`endif

//--- verilog/rtos_pkg.sv
// Kernel types shared by the core, the ready queue, the interfaces and the bus decoder
`include "rtos_defines.svh"

package rtos_pkg;

    typedef logic [$clog2(`RTOS_TASKS)-1:0]      tskid_t;
    typedef logic [`RTOS_TSKPRI_WIDTH-1:0]       tskpri_t;
    typedef logic [$clog2(`RTOS_SEMAPHORES)-1:0] semid_t;
    typedef logic [`RTOS_SEMCNT_WIDTH-1:0]       semcnt_t;
    typedef logic [`RTOS_FLGPTN_WIDTH-1:0]       flgptn_t;

    typedef enum logic [1:0] {
        TSK_READY,
        TSK_WAIT_SLP,
        TSK_WAIT_SEM,
        TSK_WAIT_FLG
    } tsk_state_e;

    // One command per cycle from the decoder
    typedef enum logic [3:0] {
        CMD_NONE, CMD_WUP_TSK, CMD_SLP_TSK, CMD_REL_WAI, CMD_CHG_PRI,
        CMD_SIG_SEM, CMD_WAI_SEM, CMD_SET_FLG, CMD_CLR_FLG,
        CMD_WAI_FLG_AND, CMD_WAI_FLG_OR
    } cmd_e;

endpackage

//--- verilog/rtos_bus_pkg.sv
// Register map of the Wishbone port with opcodes and read-back item ids, imported by the decoder
package rtos_bus_pkg;

    // Address bits 7..0
    typedef enum logic [7:0] {
        REF_INF     = 8'h00, CPU_STS     = 8'h01, REF_RDQ     = 8'h02,
        WUP_TSK     = 8'h10, SLP_TSK     = 8'h11, REL_WAI     = 8'h12,
        CHG_PRI     = 8'h13,
        SIG_SEM     = 8'h21, WAI_SEM     = 8'h22, REF_SEM     = 8'h23,
        SET_FLG     = 8'h31, CLR_FLG     = 8'h32, WAI_FLG_AND = 8'h33,
        WAI_FLG_OR  = 8'h34, REF_FLG     = 8'h35
    } opcode_e;

    // Id field items of REF_INF
    typedef enum logic [7:0] {CORE_ID = 8'h00, VERSION = 8'h01} ref_inf_e;

    // Id field items of CPU_STS
    typedef enum logic [7:0] {CPU_TASKID = 8'h00, CPU_VALID = 8'h01} cpu_sts_e;

endpackage

//--- verilog/rtos_ifs.sv
// Interfaces for decoder to kernel commands and kernel to ready queue, instanced in the top level
`timescale 1ns/1ns
`include "rtos_defines.svh"

interface rtos_cmd_if;
    import rtos_pkg::*;

    cmd_e                               cmd;
    tskid_t                             cmd_id;
    flgptn_t                            cmd_data;
    semcnt_t [`RTOS_SEMAPHORES-1:0]     semcnt;
    flgptn_t                            flgptn;

    modport decoder (output cmd, cmd_id, cmd_data, input semcnt, flgptn);
    modport kernel  (input cmd, cmd_id, cmd_data, output semcnt, flgptn);
endinterface

interface rtos_rdq_if;
    import rtos_pkg::*;

    logic [`RTOS_TASKS-1:0]             ready_mask;
    tskpri_t [`RTOS_TASKS-1:0]          tskpri;
    tskid_t                             top_tskid;
    tskpri_t                            top_tskpri;
    logic                               top_valid;

    modport kernel   (output ready_mask, tskpri, input top_tskid, top_valid);
    modport queue    (input ready_mask, tskpri, output top_tskid, top_tskpri, top_valid);
    modport observer (input top_tskid, top_tskpri, top_valid);
endinterface

//--- verilog/rtos_ready_queue.sv
// Combinational ready queue that picks the highest-priority ready task for the kernel
`timescale 1ns/1ns
`include "rtos_defines.svh"

module rtos_ready_queue (
    rtos_rdq_if.queue rdq
);
    import rtos_pkg::*;

    // --------------------------------------------------
    // Priority search
    // --------------------------------------------------
    always_comb begin : find_top
        logic    found;
        tskid_t  best_id;
        tskpri_t best_pri;

        found    = 1'b0;
        best_id  = '0;
        best_pri = '0;

        // Walk downwards so that on equal priority the lower id replaces the higher
        for (int i = `RTOS_TASKS - 1; i >= 0; i--) begin
            if (rdq.ready_mask[i] && (!found || rdq.tskpri[i] <= best_pri)) begin
                found    = 1'b1;
                best_id  = tskid_t'(i);
                best_pri = rdq.tskpri[i];
            end
        end

        rdq.top_valid  = found;
        rdq.top_tskid  = best_id;
        rdq.top_tskpri = best_pri;
    end

endmodule

//--- verilog/rtos_kernel.sv
// Kernel state and command execution for tasks, semaphores and the event flag, driven by the decoder
`timescale 1ns/1ns
`include "rtos_defines.svh"

module rtos_kernel (
    input  logic            clk,
    input  logic            reset,
    rtos_cmd_if.kernel      cmd,
    rtos_rdq_if.kernel      rdq
);
    import rtos_pkg::*;

    tsk_state_e                     tsk_state [`RTOS_TASKS];
    tskpri_t [`RTOS_TASKS-1:0]      tsk_pri;
    semcnt_t [`RTOS_SEMAPHORES-1:0] sem_cnt;
    flgptn_t                        flg_reg;

    // Wait parameters only mean something while the task waits
    semid_t                         wai_semid [`RTOS_TASKS];
    flgptn_t                        wai_ptn [`RTOS_TASKS];
    logic                           wai_flg_or [`RTOS_TASKS];

    semid_t                         cmd_semid;
    logic                           sig_hit;
    tskid_t                         sig_tskid;
    logic [`RTOS_TASKS-1:0]         flg_rel;

    // OR mode needs any pattern bit, AND mode needs all of them
    function automatic logic flg_match(flgptn_t ptn, logic or_mode, flgptn_t flags);
        if (or_mode) begin
            return |(flags & ptn);
        end
        return (flags & ptn) == ptn;
    endfunction

    assign cmd_semid = semid_t'(cmd.cmd_id);

    // --------------------------------------------------
    // Waiter search
    // --------------------------------------------------
    always_comb begin
        sig_hit   = 1'b0;
        sig_tskid = '0;
        for (int i = `RTOS_TASKS - 1; i >= 0; i--) begin
            if (tsk_state[i] == TSK_WAIT_SEM && wai_semid[i] == cmd_semid) begin
                sig_hit   = 1'b1;
                sig_tskid = tskid_t'(i);
            end
        end
        for (int i = 0; i < `RTOS_TASKS; i++) begin
            flg_rel[i] = (tsk_state[i] == TSK_WAIT_FLG) &&
                         flg_match(wai_ptn[i], wai_flg_or[i], flg_reg);
        end
    end

    // --------------------------------------------------
    // Control state
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RTOS_TASKS; i++) begin
                tsk_state[i] <= TSK_READY;
                tsk_pri[i]   <= tskpri_t'(i);
            end
            sem_cnt <= '0;
            flg_reg <= '0;
        end else begin
            // Flag waiters see last cycle's flags
            for (int i = 0; i < `RTOS_TASKS; i++) begin
                if (flg_rel[i]) begin
                    tsk_state[i] <= TSK_READY;
                end
            end
            case (cmd.cmd)
                CMD_WUP_TSK: begin
                    if (tsk_state[cmd.cmd_id] == TSK_WAIT_SLP) begin
                        tsk_state[cmd.cmd_id] <= TSK_READY;
                    end
                end
                CMD_SLP_TSK: begin
                    if (tsk_state[cmd.cmd_id] == TSK_READY) begin
                        tsk_state[cmd.cmd_id] <= TSK_WAIT_SLP;
                    end
                end
                CMD_REL_WAI: tsk_state[cmd.cmd_id] <= TSK_READY;
                CMD_CHG_PRI: tsk_pri[cmd.cmd_id] <= tskpri_t'(cmd.cmd_data);
                CMD_SIG_SEM: begin
                    if (sig_hit) begin
                        tsk_state[sig_tskid] <= TSK_READY;
                    end else if (sem_cnt[cmd_semid] != '1) begin
                        sem_cnt[cmd_semid] <= sem_cnt[cmd_semid] + 1'b1;
                    end
                end
                CMD_WAI_SEM: begin
                    if (rdq.top_valid) begin
                        if (sem_cnt[cmd_semid] != '0) begin
                            sem_cnt[cmd_semid] <= sem_cnt[cmd_semid] - 1'b1;
                        end else begin
                            tsk_state[rdq.top_tskid] <= TSK_WAIT_SEM;
                        end
                    end
                end
                CMD_SET_FLG: flg_reg <= flg_reg | cmd.cmd_data;
                CMD_CLR_FLG: flg_reg <= flg_reg & cmd.cmd_data;
                CMD_WAI_FLG_AND, CMD_WAI_FLG_OR: begin
                    if (rdq.top_valid &&
                        !flg_match(cmd.cmd_data, cmd.cmd == CMD_WAI_FLG_OR, flg_reg)) begin
                        tsk_state[rdq.top_tskid] <= TSK_WAIT_FLG;
                    end
                end
                default: ;
            endcase
        end
    end

    // Wait parameters of the top task
    always_ff @(posedge clk) begin
        if (cmd.cmd == CMD_WAI_SEM) begin
            wai_semid[rdq.top_tskid] <= cmd_semid;
        end
        if (cmd.cmd == CMD_WAI_FLG_AND || cmd.cmd == CMD_WAI_FLG_OR) begin
            wai_ptn[rdq.top_tskid]    <= cmd.cmd_data;
            wai_flg_or[rdq.top_tskid] <= (cmd.cmd == CMD_WAI_FLG_OR);
        end
    end

    always_comb begin
        for (int i = 0; i < `RTOS_TASKS; i++) begin
            rdq.ready_mask[i] = (tsk_state[i] == TSK_READY);
        end
    end

    assign rdq.tskpri = tsk_pri;
    assign cmd.semcnt = sem_cnt;
    assign cmd.flgptn = flg_reg;

endmodule

//--- verilog/rtos_bus_decoder.sv
// Wishbone slave of the kernel that decodes commands, muxes read-back data and drives the interrupt
`timescale 1ns/1ns
`include "rtos_defines.svh"

module rtos_bus_decoder (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [`RTOS_WB_ADR_WIDTH-1:0]   wb_adr_i,
    input  logic [31:0]                     wb_dat_i,
    input  logic                            wb_we_i,
    input  logic [3:0]                      wb_sel_i,
    input  logic                            wb_stb_i,
    output logic [31:0]                     wb_dat_o,
    output logic                            wb_ack_o,
    output logic                            irq_o,
    rtos_cmd_if.decoder                     cmd,
    rtos_rdq_if.observer                    rdq
);
    import rtos_pkg::*;
    import rtos_bus_pkg::*;

    opcode_e    dec_opcode;
    logic [7:0] dec_id;
    logic       wr_en;
    logic       tsk_ok;
    logic       sem_ok;
    tskid_t     cpu_tskid;
    logic       cpu_valid;

    assign dec_opcode = opcode_e'(wb_adr_i[7:0]);
    assign dec_id     = wb_adr_i[15:8];
    assign wr_en      = wb_stb_i && wb_we_i && (&wb_sel_i);
    assign tsk_ok     = (dec_id < `RTOS_TASKS);
    assign sem_ok     = (dec_id < `RTOS_SEMAPHORES);
    assign wb_ack_o   = wb_stb_i;

    // --------------------------------------------------
    // Command decode
    // --------------------------------------------------
    always_comb begin
        cmd.cmd      = CMD_NONE;
        cmd.cmd_id   = tskid_t'(dec_id);
        cmd.cmd_data = wb_dat_i;
        if (wr_en) begin
            case (dec_opcode)
                WUP_TSK:     cmd.cmd = tsk_ok ? CMD_WUP_TSK : CMD_NONE;
                SLP_TSK:     cmd.cmd = tsk_ok ? CMD_SLP_TSK : CMD_NONE;
                REL_WAI:     cmd.cmd = tsk_ok ? CMD_REL_WAI : CMD_NONE;
                CHG_PRI:     cmd.cmd = tsk_ok ? CMD_CHG_PRI : CMD_NONE;
                SIG_SEM:     cmd.cmd = sem_ok ? CMD_SIG_SEM : CMD_NONE;
                WAI_SEM:     cmd.cmd = sem_ok ? CMD_WAI_SEM : CMD_NONE;
                SET_FLG:     cmd.cmd = CMD_SET_FLG;
                CLR_FLG:     cmd.cmd = CMD_CLR_FLG;
                WAI_FLG_AND: cmd.cmd = CMD_WAI_FLG_AND;
                WAI_FLG_OR:  cmd.cmd = CMD_WAI_FLG_OR;
                default:     cmd.cmd = CMD_NONE;
            endcase
        end
    end

    // Read-back mux
    always_comb begin
        wb_dat_o = '0;
        case (dec_opcode)
            REF_INF: begin
                if (ref_inf_e'(dec_id) == CORE_ID) wb_dat_o = `RTOS_CORE_ID;
                if (ref_inf_e'(dec_id) == VERSION) wb_dat_o = `RTOS_CORE_VERSION;
            end
            REF_RDQ: wb_dat_o = {rdq.top_valid, 19'b0, rdq.top_tskpri, 5'b0, rdq.top_tskid};
            REF_SEM: wb_dat_o = sem_ok ? 32'(cmd.semcnt[semid_t'(dec_id)]) : '0;
            REF_FLG: wb_dat_o = cmd.flgptn;
            default: wb_dat_o = '0;
        endcase
    end

    // --------------------------------------------------
    // CPU status and interrupt
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            cpu_valid <= 1'b0;
        end else if (wr_en && dec_opcode == CPU_STS) begin
            if (cpu_sts_e'(dec_id) == CPU_TASKID) begin
                cpu_valid <= 1'b1;
            end else if (cpu_sts_e'(dec_id) == CPU_VALID) begin
                cpu_valid <= wb_dat_i[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && dec_opcode == CPU_STS && cpu_sts_e'(dec_id) == CPU_TASKID) begin
            cpu_tskid <= tskid_t'(wb_dat_i);
        end
    end

    // Ask for a switch when the best ready task is not the one running
    assign irq_o = cpu_valid && rdq.top_valid && (rdq.top_tskid != cpu_tskid);

endmodule

//--- verilog/rtos_top.sv
// Top level of the kernel accelerator with a plain Wishbone slave port
`timescale 1ns/1ns
`include "rtos_defines.svh"

module rtos_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [`RTOS_WB_ADR_WIDTH-1:0]   wb_adr_i,
    input  logic [31:0]                     wb_dat_i,
    input  logic                            wb_we_i,
    input  logic [3:0]                      wb_sel_i,
    input  logic                            wb_stb_i,
    output logic [31:0]                     wb_dat_o,
    output logic                            wb_ack_o,
    output logic                            irq_o
);

    rtos_cmd_if cmd_if ();
    rtos_rdq_if rdq_if ();

    rtos_bus_decoder u_decoder (
        .clk      (clk),
        .reset    (reset),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_we_i  (wb_we_i),
        .wb_sel_i (wb_sel_i),
        .wb_stb_i (wb_stb_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .irq_o    (irq_o),
        .cmd      (cmd_if.decoder),
        .rdq      (rdq_if.observer)
    );

    rtos_kernel u_kernel (
        .clk   (clk),
        .reset (reset),
        .cmd   (cmd_if.kernel),
        .rdq   (rdq_if.kernel)
    );

    rtos_ready_queue u_ready_queue (
        .rdq (rdq_if.queue)
    );

endmodule

//--- tb/rtos_properties.sv
// Concurrent checks on the Wishbone handshake and the interrupt, bound into the kernel top level
`timescale 1ns/1ns

module rtos_properties (
    input logic clk,
    input logic reset,
    input logic wb_stb_i,
    input logic wb_ack_o,
    input logic irq_o
);

    // Single-cycle slave without wait states
    ack_follows_stb: assert property (@(posedge clk) wb_ack_o == wb_stb_i)
        else $error("wb_ack_o differs from wb_stb_i");

    // CPU status is cleared by every reset edge
    irq_low_in_reset: assert property (@(posedge clk) reset |=> !irq_o)
        else $error("irq_o is high after a reset edge");

endmodule

bind rtos_top rtos_properties props0 (
    .clk      (clk),
    .reset    (reset),
    .wb_stb_i (wb_stb_i),
    .wb_ack_o (wb_ack_o),
    .irq_o    (irq_o)
);

//--- tb/rtos_tb.sv
// Self-checking testbench of the kernel accelerator, run as the simulation top with rtos_top as DUT
`timescale 1ns/1ns
`include "rtos_defines.svh"

module rtos_tb;
    import rtos_pkg::*;
    import rtos_bus_pkg::*;

    localparam int RAND_STEPS = 40;
    localparam int FLG_STEPS  = 10;
    localparam int IRQ_STEPS  = 12;
    // Fixed reads and writes outside the random loops
    localparam int OP_COUNT   = 2 * (RAND_STEPS + FLG_STEPS + IRQ_STEPS) + 84;

    logic                           clk = 1'b0;
    logic                           reset;
    logic [`RTOS_WB_ADR_WIDTH-1:0]  wb_adr_i;
    logic [31:0]                    wb_dat_i;
    logic                           wb_we_i;
    logic [3:0]                     wb_sel_i;
    logic                           wb_stb_i;
    logic [31:0]                    wb_dat_o;
    logic                           wb_ack_o;
    logic                           irq_o;

    logic [31:0]  lfsr;
    int           checks = 0;
    int           errors = 0;
    logic [31:0]  got_q[$];
    logic [31:0]  want_q[$];
    string        what_q[$];

    // Reference model state
    tsk_state_e   m_state [`RTOS_TASKS];
    tskpri_t      m_pri [`RTOS_TASKS];
    semid_t       m_semid [`RTOS_TASKS];
    flgptn_t      m_ptn [`RTOS_TASKS];
    logic         m_or [`RTOS_TASKS];
    semcnt_t      m_cnt [`RTOS_SEMAPHORES];
    flgptn_t      m_flg;
    tskid_t       m_cpu_id;
    logic         m_cpu_valid;

    rtos_top dut0 (.*);

    always #4 clk = ~clk;

    // Taps of x^32 + x^22 + x^2 + x + 1
    // One shift per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // State of the model right after a reset
    function automatic void model_reset();
        for (int i = 0; i < `RTOS_TASKS; i++) begin
            m_state[i] = TSK_READY;
            m_pri[i]   = tskpri_t'(i);
        end
        for (int i = 0; i < `RTOS_SEMAPHORES; i++) begin
            m_cnt[i] = '0;
        end
        m_flg       = '0;
        m_cpu_id    = '0;
        m_cpu_valid = 1'b0;
    endfunction

    function automatic logic flag_holds(flgptn_t ptn, logic any);
        if (any) begin
            return (m_flg & ptn) != 0;
        end
        return (ptn & ~m_flg) == 0;
    endfunction

    // Expected REF_RDQ word for the lowest priority value, then the lowest id
    function automatic logic [31:0] rtos_ref_top();
        logic    found;
        tskid_t  best;
        tskpri_t pri;
        found = 1'b0;
        best  = '0;
        pri   = '0;
        for (int i = 0; i < `RTOS_TASKS; i++) begin
            if (m_state[i] == TSK_READY && (!found || m_pri[i] < pri)) begin
                found = 1'b1;
                best  = tskid_t'(i);
                pri   = m_pri[i];
            end
        end
        return found ? {1'b1, 19'b0, pri, 5'b0, best} : 32'h0;
    endfunction

    function automatic logic [31:0] expected_read(opcode_e op, logic [7:0] id);
        case (op)
            REF_INF: return `RTOS_CORE_ID;
            REF_RDQ: return rtos_ref_top();
            REF_SEM: return 32'(m_cnt[id[1:0]]);
            REF_FLG: return m_flg;
            default: return 32'h0;
        endcase
    endfunction

    // --------------------------------------------------
    // Reference model update for one write
    // --------------------------------------------------
    function automatic void ref_apply(opcode_e op, logic [7:0] id, flgptn_t data);
        logic [31:0] top;
        tskid_t      t;
        logic        hit;
        top = rtos_ref_top();
        t   = top[2:0];
        hit = 1'b0;
        case (op)
            WUP_TSK: if (m_state[id[2:0]] == TSK_WAIT_SLP) m_state[id[2:0]] = TSK_READY;
            SLP_TSK: if (m_state[id[2:0]] == TSK_READY) m_state[id[2:0]] = TSK_WAIT_SLP;
            REL_WAI: m_state[id[2:0]] = TSK_READY;
            CHG_PRI: m_pri[id[2:0]] = data[3:0];
            SIG_SEM: begin
                for (int i = 0; i < `RTOS_TASKS; i++) begin
                    if (!hit && m_state[i] == TSK_WAIT_SEM && m_semid[i] == id[1:0]) begin
                        m_state[i] = TSK_READY;
                        hit        = 1'b1;
                    end
                end
                if (!hit && m_cnt[id[1:0]] != 4'd15) m_cnt[id[1:0]] = m_cnt[id[1:0]] + 1'b1;
            end
            WAI_SEM: begin
                if (top[31] && m_cnt[id[1:0]] != 0) begin
                    m_cnt[id[1:0]] = m_cnt[id[1:0]] - 1'b1;
                end else if (top[31]) begin
                    m_state[t] = TSK_WAIT_SEM;
                    m_semid[t] = id[1:0];
                end
            end
            SET_FLG: m_flg = m_flg | data;
            CLR_FLG: m_flg = m_flg & data;
            WAI_FLG_AND, WAI_FLG_OR: begin
                if (top[31] && !flag_holds(data, op == WAI_FLG_OR)) begin
                    m_state[t] = TSK_WAIT_FLG;
                    m_ptn[t]   = data;
                    m_or[t]    = (op == WAI_FLG_OR);
                end
            end
            CPU_STS: begin
                if (id == CPU_TASKID) begin
                    m_cpu_id    = data[2:0];
                    m_cpu_valid = 1'b1;
                end
                if (id == CPU_VALID) m_cpu_valid = data[0];
            end
            default: ;
        endcase
        // Waiters on the flag settle one edge later
        for (int i = 0; i < `RTOS_TASKS; i++) begin
            if (m_state[i] == TSK_WAIT_FLG && flag_holds(m_ptn[i], m_or[i])) begin
                m_state[i] = TSK_READY;
            end
        end
    endfunction

    task automatic wb_write(opcode_e op, logic [7:0] id, logic [31:0] data);
        @(negedge clk);
        wb_adr_i = {id, op};
        wb_dat_i = data;
        wb_we_i  = 1'b1;
        wb_sel_i = 4'hf;
        wb_stb_i = 1'b1;
        @(negedge clk);
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        ref_apply(op, id, data);
        repeat (2) @(negedge clk);
    endtask

    task automatic wb_read(opcode_e op, logic [7:0] id);
        logic [31:0] top;
        @(negedge clk);
        wb_adr_i = {id, op};
        wb_we_i  = 1'b0;
        wb_sel_i = 4'hf;
        wb_stb_i = 1'b1;
        #2;
        top = rtos_ref_top();
        got_q.push_back(wb_dat_o);
        want_q.push_back(expected_read(op, id));
        what_q.push_back($sformatf("wb_dat_o (op %h id %h)", op, id));
        got_q.push_back(32'(irq_o));
        want_q.push_back(32'(m_cpu_valid && top[31] && top[2:0] != m_cpu_id));
        what_q.push_back("irq_o");
        @(negedge clk);
        wb_stb_i = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    always @(posedge clk) begin : compare
        logic [31:0] got;
        logic [31:0] want;
        string       what;
        while (got_q.size() > 0) begin
            got  = got_q.pop_front();
            want = want_q.pop_front();
            what = what_q.pop_front();
            checks++;
            assert (got === want) else begin
                errors++;
                $display("FAIL %s: got %h, expected %h", what, got, want);
            end
        end
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin : main
        logic [1:0]  pick;
        logic [7:0]  tid;
        logic [31:0] word;
        reset    = 1'b1;
        wb_adr_i = '0;
        wb_dat_i = '0;
        wb_we_i  = 1'b0;
        wb_sel_i = 4'h0;
        wb_stb_i = 1'b0;
        lfsr     = 32'h75d7_03fb;
        model_reset();
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        wb_read(REF_INF, CORE_ID);
        wb_read(REF_RDQ, 8'h00);
        wb_read(REF_FLG, 8'h00);
        for (int i = 0; i < `RTOS_SEMAPHORES; i++) begin
            wb_read(REF_SEM, 8'(i));
        end

        // Narrow priorities so that ties are common
        for (int n = 0; n < RAND_STEPS; n++) begin
            pick = 2'(rand_bits(2));
            tid  = 8'(rand_bits(3));
            case (pick)
                2'd0:    wb_write(SLP_TSK, tid, 32'h0);
                2'd1:    wb_write(WUP_TSK, tid, 32'h0);
                2'd2:    wb_write(REL_WAI, tid, 32'h0);
                default: wb_write(CHG_PRI, tid, rand_bits(2));
            endcase
            wb_read(REF_RDQ, 8'h00);
        end
        for (int i = 0; i < `RTOS_TASKS; i++) begin
            wb_write(REL_WAI, 8'(i), 32'h0);
        end
        wb_read(REF_RDQ, 8'h00);

        // Three waiters on semaphore 1, then release one by one
        for (int n = 0; n < 6; n++) begin
            wb_write(n < 3 ? WAI_SEM : SIG_SEM, 8'h01, 32'h0);
            wb_read(REF_RDQ, 8'h00);
        end
        for (int n = 0; n < 17; n++) begin
            wb_write(SIG_SEM, 8'h02, 32'h0);
            wb_read(REF_SEM, 8'h02);
        end
        wb_write(WAI_SEM, 8'h02, 32'h0);
        wb_read(REF_SEM, 8'h02);

        for (int n = 0; n < FLG_STEPS; n++) begin
            pick = 2'(rand_bits(1));
            word = rand_bits(32);
            wb_write(pick[0] ? SET_FLG : CLR_FLG, 8'h00, word);
            wb_read(REF_FLG, 8'h00);
        end
        wb_write(CLR_FLG, 8'h00, 32'h0);
        wb_write(WAI_FLG_AND, 8'h00, 32'h0000_00f0);
        wb_read(REF_RDQ, 8'h00);
        wb_write(WAI_FLG_OR, 8'h00, 32'h0300_0000);
        wb_read(REF_RDQ, 8'h00);
        wb_write(SET_FLG, 8'h00, 32'h0000_0030);
        wb_read(REF_RDQ, 8'h00);
        wb_write(SET_FLG, 8'h00, 32'h0100_0000);
        wb_read(REF_RDQ, 8'h00);
        wb_write(SET_FLG, 8'h00, 32'h0000_00c0);
        wb_read(REF_RDQ, 8'h00);
        wb_read(REF_FLG, 8'h00);

        wb_write(CPU_STS, CPU_TASKID, rand_bits(3));
        wb_read(REF_RDQ, 8'h00);
        for (int n = 0; n < IRQ_STEPS; n++) begin
            pick = 2'(rand_bits(2));
            tid  = 8'(rand_bits(3));
            case (pick)
                2'd0:    wb_write(CPU_STS, CPU_TASKID, 32'(tid));
                2'd1:    wb_write(CPU_STS, CPU_VALID, rand_bits(1));
                2'd2:    wb_write(SLP_TSK, tid, 32'h0);
                default: wb_write(WUP_TSK, tid, 32'h0);
            endcase
            wb_read(REF_RDQ, 8'h00);
        end
        wb_write(CPU_STS, CPU_VALID, 32'h0);
        wb_read(REF_RDQ, 8'h00);

        // Reset while an interrupt is pending
        wb_write(REL_WAI, 8'h00, 32'h0);
        word = rtos_ref_top();
        wb_write(CPU_STS, CPU_TASKID, 32'(word[2:0] + 3'd1));
        wb_read(REF_RDQ, 8'h00);
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        model_reset();
        wb_read(REF_RDQ, 8'h00);

        repeat (2) @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (OP_COUNT * 4 + 200) @(posedge clk);
        $display("Timeout: the test sequence did not finish in time");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- flist.f
+incdir+verilog
verilog/rtos_pkg.sv
verilog/rtos_bus_pkg.sv
verilog/rtos_ifs.sv
verilog/rtos_ready_queue.sv
verilog/rtos_kernel.sv
verilog/rtos_bus_decoder.sv
verilog/rtos_top.sv
tb/rtos_properties.sv
tb/rtos_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the kernel testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module rtos_tb \
    --Mdir obj_dir -o rtos_sim
./obj_dir/rtos_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "NO ERRORS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
